/* all.f */
+incdir+.
support_pkg.sv
sat_event_counter.sv
obi_phase_monitor.sv
req_attribute_fifo.sv
debug_event_tracker.sv
support_logic.sv
tb_support_logic.sv

/* debug_event_tracker.sv */
/*
  Detects debug and startup events from the trace port and control path.
  Produces first debug instruction, recorded debug request, first fetch
  and data request after an exception.
*/

`timescale 1ns/1ps
`default_nettype none

`include "support_defines.svh"

module debug_event_tracker (
  input  logic                   in_support_if,
  input  logic                   rst_n_i,
  input  support_pkg::rvfi_evt_t rvfi_i,
  input  support_pkg::ctrl_t     ctrl_i,
  input  support_pkg::obi_bus_t  data_bus_i,
  input  logic                   fetch_enable_i,
  input  logic                   debug_req_i,
  output support_pkg::sl_flags_t flags_o
);

  localparam int HOLD_W = $clog2(`SL_DBG_HOLD + 1);
  localparam logic [HOLD_W-1:0] HOLD_FULL = HOLD_W'(`SL_DBG_HOLD);
  localparam logic [HOLD_W-1:0] HOLD_RET  = HOLD_W'(`SL_DBG_HOLD - 1);

  logic              in_debug_q;
  logic              dret_pend_q;
  logic              fetch_seen_q;
  logic [HOLD_W-1:0] dbg_hold_q;
  logic              data_gnt_q;
  logic              exc_open_q;
  logic              req_after_exc_q;
  logic              trap_taken;
  logic              req_after_gnt;

  // ----------------------------------------
  // first debug instruction
  // ----------------------------------------

  // last retirement was in debug mode
  // a completed dret makes the next retirement count as fresh entry
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_debug_q  <= 1'b0;
      dret_pend_q <= 1'b0;
    end else if (rvfi_i.valid) begin
      in_debug_q  <= rvfi_i.dbg_mode;
      dret_pend_q <= rvfi_i.is_dret && !rvfi_i.trap;
    end
  end

  assign flags_o.first_debug_ins = rvfi_i.valid && rvfi_i.dbg_mode &&
                                   (!in_debug_q || dret_pend_q);

  // ----------------------------------------
  // recorded debug request
  // ----------------------------------------

  // remaining retirements the request stays recorded
  // a request on a retirement already spends one of them
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dbg_hold_q <= '0;
    end else if (debug_req_i) begin
      dbg_hold_q <= rvfi_i.valid ? HOLD_RET : HOLD_FULL;
    end else if (rvfi_i.valid && (dbg_hold_q != '0)) begin
      dbg_hold_q <= dbg_hold_q - 1'b1;
    end
  end

  assign flags_o.recorded_dbg_req = (dbg_hold_q != '0);

  // ----------------------------------------
  // first fetch
  // ----------------------------------------

  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_seen_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_seen_q <= 1'b1;
    end
  end

  // only the very first enable cycle after reset
  assign flags_o.first_fetch = fetch_enable_i && !fetch_seen_q;

  // ----------------------------------------
  // data request after exception
  // ----------------------------------------

  // trap taken in WB through the exception or debug-exception vector
  assign trap_taken = ctrl_i.pc_set &&
                      ((ctrl_i.pc_mux == support_pkg::PC_TRAP_EXC) ||
                       (ctrl_i.pc_mux == support_pkg::PC_TRAP_DBE));

  // new data request right behind a granted one
  assign req_after_gnt = data_bus_i.req && data_gnt_q;

  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      data_gnt_q      <= 1'b0;
      exc_open_q      <= 1'b0;
      req_after_exc_q <= 1'b0;
    end else begin
      data_gnt_q <= data_bus_i.gnt;
      if (trap_taken) begin
        exc_open_q <= 1'b1;
        if (req_after_gnt) begin
          req_after_exc_q <= 1'b1;
        end
      end else if (rvfi_i.valid) begin
        // retirement closes the exception window
        exc_open_q      <= 1'b0;
        req_after_exc_q <= 1'b0;
      end else if (exc_open_q && req_after_gnt) begin
        req_after_exc_q <= 1'b1;
      end
    end
  end

  assign flags_o.req_after_exception = req_after_exc_q;

endmodule

`default_nettype wire

/* obi_phase_monitor.sv */
/*
  Tracks address and response phases of one OBI bus.
  Reports a held address phase, a pending response and a granted-request count.
*/

`timescale 1ns/1ps
`default_nettype none

`include "support_defines.svh"

module obi_phase_monitor (
  input  logic                    in_support_if,
  input  logic                    rst_n_i,
  input  support_pkg::obi_bus_t   bus_i,
  output support_pkg::obi_phase_t phase_o
);

  localparam int OUT_W = $clog2(`SL_FIFO_DEPTH + 1);
  localparam logic [OUT_W-1:0] OUT_MAX = OUT_W'(`SL_FIFO_DEPTH);

  // address phase FSM
  typedef enum logic {
    ADDR_IDLE,
    ADDR_WAIT
  } addr_state_e;

  addr_state_e      addr_state_q;
  addr_state_e      addr_state_d;
  logic             addr_grant;
  logic [OUT_W-1:0] outstanding_q;

  // ----------------------------------------
  // address phase
  // ----------------------------------------

  // address phase ends when req and gnt meet
  assign addr_grant = bus_i.req && bus_i.gnt;

  // an ungranted req leaves the bus waiting for gnt
  always_comb begin
    addr_state_d = ADDR_IDLE;
    if (bus_i.req && !bus_i.gnt) begin
      addr_state_d = ADDR_WAIT;
    end
  end

  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_state_q <= ADDR_IDLE;
    end else begin
      addr_state_q <= addr_state_d;
    end
  end

  // ----------------------------------------
  // response phase
  // ----------------------------------------

  // grant adds one request, rvalid retires one
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= '0;
    end else begin
      case ({addr_grant, bus_i.rvalid})
        2'b10: begin
          if (outstanding_q != OUT_MAX) begin
            outstanding_q <= outstanding_q + 1'b1;
          end
        end
        2'b01: begin
          if (outstanding_q != '0) begin
            outstanding_q <= outstanding_q - 1'b1;
          end
        end
        default: begin
          outstanding_q <= outstanding_q;
        end
      endcase
    end
  end

  // still waiting on gnt for the same request
  assign phase_o.addr_ph_cont = (addr_state_q == ADDR_WAIT) && bus_i.req;
  // something granted and its rvalid not here yet
  assign phase_o.resp_ph_cont = (outstanding_q != '0) && !bus_i.rvalid;

  // granted address phases
  sat_event_counter i_addr_ph_cnt (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .inc_i         (addr_grant),
    .count_o       (phase_o.v_addr_ph_cnt)
  );

  // ----------------------------------------
  // protocol checks
  // ----------------------------------------

  // OBI forbids withdrawing a request before its grant
  a_req_held_until_gnt : assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    (bus_i.req && !bus_i.gnt) |=> bus_i.req
  );

  // every rvalid needs an earlier grant
  a_rvalid_has_outstanding : assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    bus_i.rvalid |-> (outstanding_q != '0)
  );

endmodule

`default_nettype wire

/* req_attribute_fifo.sv */
/*
  Carries a per-request attribute from the address phase to its response.
  Payload type is a parameter, so one FIFO serves data and instruction buses.
*/

`timescale 1ns/1ps
`default_nettype none

`include "support_defines.svh"

module req_attribute_fifo #(
  parameter type attr_t = logic
) (
  input  logic                  in_support_if,
  input  logic                  rst_n_i,
  input  support_pkg::obi_bus_t bus_i,
  input  attr_t                 attr_i,
  output attr_t                 resp_attr_o
);

  localparam int DEPTH = `SL_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  attr_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // write on a completed address phase, read on a response
  assign push = bus_i.req && bus_i.gnt;
  assign pop  = bus_i.rvalid;

  // ----------------------------------------
  // storage
  // ----------------------------------------

  always_ff @(posedge in_support_if) begin
    if (push) begin
      mem[wr_ptr_q] <= attr_i;
    end
  end

  // pointers wrap at the last entry
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // fill level, only used by the checks below
  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // head of the queue belongs to the response in this cycle
  assign resp_attr_o = pop ? mem[rd_ptr_q] : attr_t'('0);

  // ----------------------------------------
  // protocol checks
  // ----------------------------------------

  // more grants than responses would exceed the tracked depth
  a_no_overflow : assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    (push && !pop) |-> (count_q != CNT_FULL)
  );

  // a response without a stored request has no attribute to return
  a_no_underflow : assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    pop |-> (count_q != '0)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tb_support_logic -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "TB PASSED" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

/* sat_event_counter.sv */
/*
  Counts single-cycle event pulses and stops at all ones.
  Used for granted address phases and interrupt counts.
*/

`timescale 1ns/1ps
`default_nettype none

`include "support_defines.svh"

module sat_event_counter (
  input  logic                 in_support_if,
  input  logic                 rst_n_i,
  input  logic                 inc_i,
  output logic [`SL_CNT_W-1:0] count_o
);

  logic at_max;

  // stop counting once every bit is set
  assign at_max = &count_o;

  always_ff @(posedge in_support_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_o <= '0;
    end else if (inc_i && !at_max) begin
      count_o <= count_o + 1'b1;
    end
  end

  // once saturated it stays saturated until reset
  a_no_wrap : assert property (
    @(posedge in_support_if) disable iff (!rst_n_i)
    at_max |=> at_max
  );

endmodule

`default_nettype wire

/* support_defines.svh */
/*
  Sizing constants for the verification support logic.
  Include this in any file that needs FIFO depth, counter width or debug hold.
*/

`ifndef SUPPORT_DEFINES_SVH
`define SUPPORT_DEFINES_SVH

// ----------------------------------------
// OBI tracking
// ----------------------------------------

// most OBI requests that can be outstanding on one bus
`define SL_FIFO_DEPTH 4

// ----------------------------------------
// counters and debug
// ----------------------------------------

// width of every saturating counter, small so saturation shows up in test
`define SL_CNT_W 4

// retirements a recorded debug request stays visible
`define SL_DBG_HOLD 2

`endif

/* support_logic.sv */
/*
  Top of the support logic that watches the core's OBI buses, trace and control.
  Feeds flags and counters to the assertion and coverage modules.
*/

`timescale 1ns/1ps
`default_nettype none

`include "support_defines.svh"

module support_logic (
  input  logic                    in_support_if,
  input  logic                    rst_n_i,
  input  support_pkg::obi_bus_t   data_bus_i,
  input  support_pkg::obi_bus_t   instr_bus_i,
  input  support_pkg::data_attr_t data_attr_i,
  input  logic                    instr_integrity_i,
  input  support_pkg::rvfi_evt_t  rvfi_i,
  input  support_pkg::ctrl_t      ctrl_i,
  input  logic                    fetch_enable_i,
  input  logic                    debug_req_i,
  input  logic                    irq_ack_i,
  output support_pkg::obi_phase_t data_phase_o,
  output support_pkg::obi_phase_t instr_phase_o,
  output support_pkg::data_attr_t data_resp_attr_o,
  output logic                    instr_resp_integrity_o,
  output support_pkg::sl_flags_t  flags_o,
  output logic [`SL_CNT_W-1:0]    cnt_irq_ack_o,
  output logic [`SL_CNT_W-1:0]    cnt_rvfi_irqs_o
);

  logic rvfi_irq_inc;

  // ----------------------------------------
  // OBI phase monitors
  // ----------------------------------------

  obi_phase_monitor i_data_phase (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .phase_o       (data_phase_o)
  );

  obi_phase_monitor i_instr_phase (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .phase_o       (instr_phase_o)
  );

  // ----------------------------------------
  // request attributes
  // ----------------------------------------

  // store and integrity bits of each data request
  req_attribute_fifo #(
    .attr_t (support_pkg::data_attr_t)
  ) i_data_attr_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (data_bus_i),
    .attr_i        (data_attr_i),
    .resp_attr_o   (data_resp_attr_o)
  );

  // integrity bit of each fetch
  req_attribute_fifo #(
    .attr_t (logic)
  ) i_instr_attr_fifo (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .bus_i         (instr_bus_i),
    .attr_i        (instr_integrity_i),
    .resp_attr_o   (instr_resp_integrity_o)
  );

  // ----------------------------------------
  // debug and startup events
  // ----------------------------------------

  debug_event_tracker i_debug_events (
    .in_support_if  (in_support_if),
    .rst_n_i        (rst_n_i),
    .rvfi_i         (rvfi_i),
    .ctrl_i         (ctrl_i),
    .data_bus_i     (data_bus_i),
    .fetch_enable_i (fetch_enable_i),
    .debug_req_i    (debug_req_i),
    .flags_o        (flags_o)
  );

  // ----------------------------------------
  // interrupt counters
  // ----------------------------------------

  // causes 1024..1027 are not real interrupts and are not counted
  assign rvfi_irq_inc = rvfi_i.valid && rvfi_i.intr &&
                        !(rvfi_i.intr_cause inside {[11'd1024:11'd1027]});

  sat_event_counter i_cnt_irq_ack (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .inc_i         (irq_ack_i),
    .count_o       (cnt_irq_ack_o)
  );

  sat_event_counter i_cnt_rvfi_irqs (
    .in_support_if (in_support_if),
    .rst_n_i       (rst_n_i),
    .inc_i         (rvfi_irq_inc),
    .count_o       (cnt_rvfi_irqs_o)
  );

endmodule

`default_nettype wire

/* support_pkg.sv */
/*
  Shared types for the support logic and its testbench.
  Bus snapshots, phase flags, request attributes, trace events and output flags.
*/

`default_nettype none

`include "support_defines.svh"

package support_pkg;

  // ----------------------------------------
  // OBI bus view
  // ----------------------------------------

  // handshake wires of one OBI bus, as observed
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
  } obi_bus_t;

  // phase state derived from one OBI bus
  typedef struct packed {
    logic                 addr_ph_cont;
    logic                 resp_ph_cont;
    logic [`SL_CNT_W-1:0] v_addr_ph_cnt;
  } obi_phase_t;

  // attribute carried from a data request to its response
  typedef struct packed {
    logic is_store;
    logic integrity;
  } data_attr_t;

  // ----------------------------------------
  // core control and trace
  // ----------------------------------------

  // pc mux selection in the controller
  typedef enum logic [1:0] {
    PC_BOOT     = 2'd0,
    PC_JUMP     = 2'd1,
    PC_TRAP_EXC = 2'd2,
    PC_TRAP_DBE = 2'd3
  } pc_mux_e;

  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
  } ctrl_t;

  // one retirement of the trace port
  typedef struct packed {
    logic        valid;
    logic        dbg_mode;
    logic        is_dret;
    logic        trap;
    logic        intr;
    logic [10:0] intr_cause;
  } rvfi_evt_t;

  // event flags handed to assertion and coverage modules
  typedef struct packed {
    logic req_after_exception;
    logic first_debug_ins;
    logic recorded_dbg_req;
    logic first_fetch;
  } sl_flags_t;

endpackage

`default_nettype wire

/* tb_support_logic.sv */
/*
  Testbench for the verification support logic.
  Fills a per-cycle table of inputs and expected outputs, then plays it on the DUT
  and compares every selected output just before the next clock edge.
*/

`timescale 1ns/1ps
`default_nettype none

`include "support_defines.svh"

module tb_support_logic;

  localparam int RST_TIMEOUT = 64;

  // which outputs a row compares
  localparam logic [5:0] CHK_DATA  = 6'b000001;
  localparam logic [5:0] CHK_DRESP = 6'b000010;
  localparam logic [5:0] CHK_INSTR = 6'b000100;
  localparam logic [5:0] CHK_IRESP = 6'b001000;
  localparam logic [5:0] CHK_FLAGS = 6'b010000;
  localparam logic [5:0] CHK_CNT   = 6'b100000;
  localparam logic [5:0] CHK_ALL   = 6'b111111;

  typedef logic [`SL_CNT_W-1:0] cnt_t;

  // one clock cycle of stimulus and its expected outputs
  typedef struct packed {
    logic [3:0]              test;
    logic [5:0]              chk;
    support_pkg::obi_bus_t   data_bus;
    support_pkg::obi_bus_t   instr_bus;
    support_pkg::data_attr_t data_attr;
    logic                    instr_int;
    support_pkg::rvfi_evt_t  rvfi;
    support_pkg::ctrl_t      ctrl;
    logic                    fetch_en;
    logic                    dbg_req;
    logic                    irq_ack;
    support_pkg::obi_phase_t exp_data_ph;
    support_pkg::obi_phase_t exp_instr_ph;
    support_pkg::data_attr_t exp_data_resp;
    logic                    exp_instr_resp;
    support_pkg::sl_flags_t  exp_flags;
    cnt_t                    exp_ack;
    cnt_t                    exp_irqs;
  } row_t;

  logic                    in_support_if;
  logic                    rst_n_i;
  support_pkg::obi_bus_t   data_bus_i;
  support_pkg::obi_bus_t   instr_bus_i;
  support_pkg::data_attr_t data_attr_i;
  logic                    instr_integrity_i;
  support_pkg::rvfi_evt_t  rvfi_i;
  support_pkg::ctrl_t      ctrl_i;
  logic                    fetch_enable_i;
  logic                    debug_req_i;
  logic                    irq_ack_i;
  support_pkg::obi_phase_t data_phase_o;
  support_pkg::obi_phase_t instr_phase_o;
  support_pkg::data_attr_t data_resp_attr_o;
  logic                    instr_resp_integrity_o;
  support_pkg::sl_flags_t  flags_o;
  cnt_t                    cnt_irq_ack_o;
  cnt_t                    cnt_rvfi_irqs_o;

  row_t                    table_q[$];
  row_t                    r;
  // in-order reference of the attribute FIFOs
  support_pkg::data_attr_t data_model_q[$];
  logic                    instr_model_q[$];
  logic [31:0]             lcg_state;
  int                      cur_row;
  int                      errors;
  int                      checks;
  int                      test_errors;
  int                      tests_done;

  support_logic i_support_logic (
    .in_support_if          (in_support_if),
    .rst_n_i                (rst_n_i),
    .data_bus_i             (data_bus_i),
    .instr_bus_i            (instr_bus_i),
    .data_attr_i            (data_attr_i),
    .instr_integrity_i      (instr_integrity_i),
    .rvfi_i                 (rvfi_i),
    .ctrl_i                 (ctrl_i),
    .fetch_enable_i         (fetch_enable_i),
    .debug_req_i            (debug_req_i),
    .irq_ack_i              (irq_ack_i),
    .data_phase_o           (data_phase_o),
    .instr_phase_o          (instr_phase_o),
    .data_resp_attr_o       (data_resp_attr_o),
    .instr_resp_integrity_o (instr_resp_integrity_o),
    .flags_o                (flags_o),
    .cnt_irq_ack_o          (cnt_irq_ack_o),
    .cnt_rvfi_irqs_o        (cnt_rvfi_irqs_o)
  );

  // ----------------------------------------
  // clock and reset
  // ----------------------------------------

  initial begin
    in_support_if = 1'b0;
    forever #50 in_support_if = ~in_support_if;
  end

  initial begin
    rst_n_i = 1'b0;
    repeat (16) @(posedge in_support_if);
    #5 rst_n_i = 1'b1;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic string test_name(input logic [3:0] t);
    case (t)
      4'd0:    return "reset values";
      4'd1:    return "data bus phases";
      4'd2:    return "instr bus phases";
      4'd3:    return "debug entry";
      4'd4:    return "debug req and fetch";
      4'd5:    return "req after exception";
      default: return "irq counters";
    endcase
  endfunction

  // ----------------------------------------
  // table fill
  // ----------------------------------------

  task automatic new_row(input logic [3:0] test, input logic [5:0] chk);
    r      = '0;
    r.test = test;
    r.chk  = chk;
  endtask

  task automatic push_row();
    table_q.push_back(r);
  endtask

  // data bus cycle, response attribute comes from the reference queue
  task automatic data_row(input logic req, input logic gnt, input logic rv,
                          input support_pkg::data_attr_t attr,
                          input logic e_addr, input logic e_resp, input cnt_t e_cnt);
    new_row(4'd1, CHK_DATA | CHK_DRESP);
    r.data_bus.req                = req;
    r.data_bus.gnt                = gnt;
    r.data_bus.rvalid             = rv;
    r.data_attr                   = attr;
    r.exp_data_ph.addr_ph_cont    = e_addr;
    r.exp_data_ph.resp_ph_cont    = e_resp;
    r.exp_data_ph.v_addr_ph_cnt   = e_cnt;
    if (rv) begin
      r.exp_data_resp = data_model_q.pop_front();
    end
    if (req && gnt) begin
      data_model_q.push_back(attr);
    end
    push_row();
  endtask

  task automatic instr_row(input logic req, input logic gnt, input logic rv,
                           input logic integ,
                           input logic e_addr, input logic e_resp, input cnt_t e_cnt);
    new_row(4'd2, CHK_INSTR | CHK_IRESP);
    r.instr_bus.req              = req;
    r.instr_bus.gnt              = gnt;
    r.instr_bus.rvalid           = rv;
    r.instr_int                  = integ;
    r.exp_instr_ph.addr_ph_cont  = e_addr;
    r.exp_instr_ph.resp_ph_cont  = e_resp;
    r.exp_instr_ph.v_addr_ph_cnt = e_cnt;
    if (rv) begin
      r.exp_instr_resp = instr_model_q.pop_front();
    end
    if (req && gnt) begin
      instr_model_q.push_back(integ);
    end
    push_row();
  endtask

  // flags order is {req_after_exception, first_debug_ins, recorded_dbg_req, first_fetch}
  task automatic flag_row(input logic [3:0] test, input logic valid, input logic dbg,
                          input logic dret, input logic dreq, input logic fetch,
                          input logic [3:0] e_flags);
    new_row(test, CHK_FLAGS);
    r.rvfi.valid    = valid;
    r.rvfi.dbg_mode = dbg;
    r.rvfi.is_dret  = dret;
    r.dbg_req       = dreq;
    r.fetch_en      = fetch;
    r.exp_flags     = e_flags;
  endtask

  task automatic fill_table();
    support_pkg::data_attr_t a0;
    support_pkg::data_attr_t a1;
    support_pkg::data_attr_t a2;
    logic                    i0;
    cnt_t                    ack_cnt;
    cnt_t                    irq_cnt;
    logic                    filtered;
    new_row(4'd0, CHK_ALL);
    push_row();
    lcg_state = lcg_step(lcg_state);
    a0        = lcg_state[17:16];
    lcg_state = lcg_step(lcg_state);
    a1        = lcg_state[17:16];
    lcg_state = lcg_step(lcg_state);
    a2        = lcg_state[17:16];
    lcg_state = lcg_step(lcg_state);
    i0        = lcg_state[20];
    // A waits one cycle, B waits two, C is granted at once
    data_row(1, 0, 0, a0, 0, 0, 4'd0);
    data_row(1, 1, 0, a0, 1, 0, 4'd0);
    data_row(1, 0, 0, a1, 0, 1, 4'd1);
    data_row(1, 0, 0, a1, 1, 1, 4'd1);
    data_row(1, 1, 1, a1, 1, 0, 4'd1);
    data_row(1, 1, 0, a2, 0, 1, 4'd2);
    data_row(0, 0, 0, '0, 0, 1, 4'd3);
    data_row(0, 0, 1, '0, 0, 0, 4'd3);
    data_row(0, 0, 0, '0, 0, 1, 4'd3);
    data_row(0, 0, 1, '0, 0, 0, 4'd3);
    data_row(0, 0, 0, '0, 0, 0, 4'd3);
    // fetch held for three cycles before its grant
    instr_row(1, 0, 0, i0, 0, 0, 4'd0);
    instr_row(1, 0, 0, i0, 1, 0, 4'd0);
    instr_row(1, 0, 0, i0, 1, 0, 4'd0);
    instr_row(1, 1, 0, i0, 1, 0, 4'd0);
    instr_row(0, 0, 0, 0, 0, 1, 4'd1);
    instr_row(0, 0, 0, 0, 0, 1, 4'd1);
    instr_row(0, 0, 1, 0, 0, 0, 4'd1);
    instr_row(0, 0, 0, 0, 0, 0, 4'd1);
    // enter debug, dret out, re-enter, then dret straight into debug again
    flag_row(4'd3, 1, 0, 0, 0, 0, 4'b0000); push_row();
    flag_row(4'd3, 0, 0, 0, 0, 0, 4'b0000); push_row();
    flag_row(4'd3, 1, 1, 0, 0, 0, 4'b0100); push_row();
    flag_row(4'd3, 1, 1, 0, 0, 0, 4'b0000); push_row();
    flag_row(4'd3, 0, 0, 0, 0, 0, 4'b0000); push_row();
    flag_row(4'd3, 1, 1, 1, 0, 0, 4'b0000); push_row();
    flag_row(4'd3, 1, 0, 0, 0, 0, 4'b0000); push_row();
    flag_row(4'd3, 1, 1, 0, 0, 0, 4'b0100); push_row();
    flag_row(4'd3, 1, 1, 0, 0, 0, 4'b0000); push_row();
    flag_row(4'd3, 1, 1, 1, 0, 0, 4'b0000); push_row();
    flag_row(4'd3, 1, 1, 0, 0, 0, 4'b0100); push_row();
    flag_row(4'd3, 1, 0, 0, 0, 0, 4'b0000); push_row();
    // request off a retirement holds for two retirements, on one for a single one
    flag_row(4'd4, 0, 0, 0, 1, 0, 4'b0000); push_row();
    flag_row(4'd4, 0, 0, 0, 0, 0, 4'b0010); push_row();
    flag_row(4'd4, 1, 0, 0, 0, 0, 4'b0010); push_row();
    flag_row(4'd4, 0, 0, 0, 0, 0, 4'b0010); push_row();
    flag_row(4'd4, 1, 0, 0, 0, 0, 4'b0010); push_row();
    flag_row(4'd4, 0, 0, 0, 0, 1, 4'b0001); push_row();
    flag_row(4'd4, 1, 0, 0, 1, 1, 4'b0000); push_row();
    flag_row(4'd4, 0, 0, 0, 0, 1, 4'b0010); push_row();
    flag_row(4'd4, 1, 0, 0, 0, 1, 4'b0010); push_row();
    flag_row(4'd4, 0, 0, 0, 0, 0, 4'b0000); push_row();
    flag_row(4'd4, 0, 0, 0, 0, 1, 4'b0000); push_row();
    // exception trap, then a request right behind a granted one
    flag_row(4'd5, 0, 0, 0, 0, 0, 4'b0000);
    r.ctrl.pc_set = 1'b1;
    r.ctrl.pc_mux = support_pkg::PC_TRAP_EXC;
    push_row();
    flag_row(4'd5, 0, 0, 0, 0, 0, 4'b0000);
    r.data_bus = 3'b110;
    push_row();
    flag_row(4'd5, 0, 0, 0, 0, 0, 4'b0000);
    r.data_bus = 3'b110;
    push_row();
    flag_row(4'd5, 0, 0, 0, 0, 0, 4'b1000);
    r.data_bus = 3'b001;
    push_row();
    flag_row(4'd5, 1, 0, 0, 0, 0, 4'b1000);
    push_row();
    flag_row(4'd5, 0, 0, 0, 0, 0, 4'b0000);
    r.data_bus = 3'b001;
    push_row();
    // debug exception trap with a request that had no grant before it
    flag_row(4'd5, 0, 0, 0, 0, 0, 4'b0000);
    r.ctrl.pc_set = 1'b1;
    r.ctrl.pc_mux = support_pkg::PC_TRAP_DBE;
    push_row();
    flag_row(4'd5, 0, 0, 0, 0, 0, 4'b0000);
    r.data_bus = 3'b100;
    push_row();
    flag_row(4'd5, 0, 0, 0, 0, 0, 4'b0000);
    r.data_bus = 3'b110;
    push_row();
    flag_row(4'd5, 0, 0, 0, 0, 0, 4'b0000);
    r.data_bus = 3'b001;
    push_row();
    flag_row(4'd5, 1, 0, 0, 0, 0, 4'b0000);
    push_row();
    // twenty acks and interrupt retirements, causes 1024..1027 not counted
    ack_cnt = '0;
    irq_cnt = '0;
    for (int k = 0; k < 20; k++) begin
      new_row(4'd6, CHK_CNT);
      filtered       = (k % 5 == 1);
      r.irq_ack      = 1'b1;
      r.rvfi.valid   = 1'b1;
      r.rvfi.intr    = 1'b1;
      if (filtered) begin
        r.rvfi.intr_cause = 11'd1024 + 11'((k / 5) % 4);
      end else if (k % 5 == 3) begin
        r.rvfi.intr_cause = (k % 10 == 3) ? 11'd1023 : 11'd1028;
      end else begin
        r.rvfi.intr_cause = 11'(16 + k);
      end
      r.exp_ack  = ack_cnt;
      r.exp_irqs = irq_cnt;
      push_row();
      if (ack_cnt != '1) begin
        ack_cnt = ack_cnt + 1'b1;
      end
      if (!filtered && irq_cnt != '1) begin
        irq_cnt = irq_cnt + 1'b1;
      end
    end
    new_row(4'd6, CHK_CNT);
    r.exp_ack  = ack_cnt;
    r.exp_irqs = irq_cnt;
    push_row();
  endtask

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------

  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_phase(input string name, input support_pkg::obi_phase_t got,
                             input support_pkg::obi_phase_t exp);
    checks++;
    if (got !== exp) begin
      note_error();
      $display("mismatch row %0d %s: got %h expected %h", cur_row, name, got, exp);
    end
  endtask

  task automatic check_attr(input string name, input support_pkg::data_attr_t got,
                            input support_pkg::data_attr_t exp);
    checks++;
    if (got !== exp) begin
      note_error();
      $display("mismatch row %0d %s: got %h expected %h", cur_row, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      note_error();
      $display("mismatch row %0d %s: got %h expected %h", cur_row, name, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input support_pkg::sl_flags_t got,
                             input support_pkg::sl_flags_t exp);
    checks++;
    if (got !== exp) begin
      note_error();
      $display("mismatch row %0d %s: got %h expected %h", cur_row, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
    checks++;
    if (got !== exp) begin
      note_error();
      $display("mismatch row %0d %s: got %h expected %h", cur_row, name, got, exp);
    end
  endtask

  // ----------------------------------------
  // table playback
  // ----------------------------------------

  task automatic drive_row(input row_t row);
    data_bus_i        = row.data_bus;
    instr_bus_i       = row.instr_bus;
    data_attr_i       = row.data_attr;
    instr_integrity_i = row.instr_int;
    rvfi_i            = row.rvfi;
    ctrl_i            = row.ctrl;
    fetch_enable_i    = row.fetch_en;
    debug_req_i       = row.dbg_req;
    irq_ack_i         = row.irq_ack;
  endtask

  task automatic check_row(input row_t row);
    if ((row.chk & CHK_DATA) != '0) begin
      check_phase("data_phase_o", data_phase_o, row.exp_data_ph);
    end
    if ((row.chk & CHK_DRESP) != '0) begin
      check_attr("data_resp_attr_o", data_resp_attr_o, row.exp_data_resp);
    end
    if ((row.chk & CHK_INSTR) != '0) begin
      check_phase("instr_phase_o", instr_phase_o, row.exp_instr_ph);
    end
    if ((row.chk & CHK_IRESP) != '0) begin
      check_bit("instr_resp_integrity_o", instr_resp_integrity_o, row.exp_instr_resp);
    end
    if ((row.chk & CHK_FLAGS) != '0) begin
      check_flags("flags_o", flags_o, row.exp_flags);
    end
    if ((row.chk & CHK_CNT) != '0) begin
      check_count("cnt_irq_ack_o", cnt_irq_ack_o, row.exp_ack);
      check_count("cnt_rvfi_irqs_o", cnt_rvfi_irqs_o, row.exp_irqs);
    end
  endtask

  task automatic run_table();
    int n;
    n = table_q.size();
    for (int i = 0; i < n; i++) begin
      @(posedge in_support_if);
      #5;
      drive_row(table_q[i]);
      // sample late in the cycle, well clear of the next edge
      #90;
      cur_row = i;
      check_row(table_q[i]);
      if (i == n - 1 || table_q[i + 1].test != table_q[i].test) begin
        $display("test %0d %s done, %0d errors", table_q[i].test,
                 test_name(table_q[i].test), test_errors);
        tests_done++;
        test_errors = 0;
      end
    end
  endtask

  initial begin
    int cycles;
    data_bus_i        = '0;
    instr_bus_i       = '0;
    data_attr_i       = '0;
    instr_integrity_i = 1'b0;
    rvfi_i            = '0;
    ctrl_i            = '0;
    fetch_enable_i    = 1'b0;
    debug_req_i       = 1'b0;
    irq_ack_i         = 1'b0;
    errors            = 0;
    checks            = 0;
    test_errors       = 0;
    tests_done        = 0;
    cur_row           = 0;
    lcg_state         = 32'h81907b60;
    fill_table();
    cycles = 0;
    while (rst_n_i !== 1'b1 && cycles < RST_TIMEOUT) begin
      @(posedge in_support_if);
      cycles++;
    end
    if (rst_n_i !== 1'b1) begin
      $display("reset was not released within %0d cycles", RST_TIMEOUT);
      $display("TB FAILED");
      $finish;
    end else begin
      run_table();
      $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
      if (errors == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
